// ==== common/udp_rx_pkg.sv ====
package udp_rx_pkg;

    // ======================================================================
    // Stream geometry
    // ======================================================================

    // Bytes per beat and data width of the MAC stream
    localparam int DATA_BYTES = 4;
    localparam int DATA_W     = DATA_BYTES * 8;

    // Beats captured before the validator is asked (bytes 0..39)
    localparam int HDR_BEATS = 10;

    // Lanes of the first payload beat still holding UDP header bytes
    localparam int PAY_OFFSET = 2;

    // Subtracted from the UDP length to get the payload length
    localparam int UDP_HDR_LEN = 8;

    // ======================================================================
    // Field byte offsets within the frame
    // ======================================================================
    localparam int OFF_DST_MAC   = 0;
    localparam int OFF_SRC_MAC   = 6;
    localparam int OFF_ETHERTYPE = 12;
    localparam int OFF_IP        = 14;
    localparam int OFF_TOTAL_LEN = 16;
    localparam int OFF_PROTOCOL  = 23;
    localparam int OFF_SRC_IP    = 26;
    localparam int OFF_DST_IP    = 30;
    localparam int OFF_SRC_PORT  = 34;
    localparam int OFF_DST_PORT  = 36;
    localparam int OFF_UDP_LEN   = 38;

    // 16-bit words of the 20-byte IPv4 header, checksum field included
    localparam int IP_SUM_WORDS = 10;

    // Protocol identifiers for a UDP over IPv4 frame
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // One stream beat, lane 0 in data[7:0]
    typedef struct packed {
        logic [DATA_W-1:0]     data;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        logic                  user;
    } axis_beat_t;

    // Raw header beats, index is the beat number
    typedef logic [HDR_BEATS-1:0][DATA_W-1:0] hdr_raw_t;

    // Extracted header, multi-byte fields in network order
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [3:0]  ip_version;
        logic [3:0]  ip_ihl;
        logic [7:0]  protocol;
        logic [15:0] total_len;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [31:0] csum_accum;
        logic [15:0] payload_len;
    } udp_hdr_t;

endpackage

// ==== frame_ctrl/rx_frame_ctrl.sv ====
`timescale 1ns/1ns

module rx_frame_ctrl
    import udp_rx_pkg::*;
(
    input  logic       iClk,
    input  logic       arst_n,
    input  axis_beat_t eth_in,
    input  logic       eth_valid,
    output logic       eth_ready,
    output hdr_raw_t   hdr_raw,
    output logic       hdr_done,
    input  logic       accept,
    input  logic       drop,
    output axis_beat_t fwd_beat,
    output logic       fwd_valid,
    output logic       fwd_first,
    input  logic       fwd_ready,
    output logic       stat_dropped
);

    localparam int CNT_W = $clog2(HDR_BEATS);
    localparam logic [CNT_W-1:0] LAST_HDR = CNT_W'(HDR_BEATS - 1);

    // IDLE takes beat 0, HDR the rest of the header
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR,
        ST_VERDICT,
        ST_PAYLOAD,
        ST_ABSORB
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] beat_cnt;
    logic             xfer;
    logic             in_hdr;
    logic             hdr_abort;

    assign xfer      = eth_valid && eth_ready;
    assign in_hdr    = (state == ST_IDLE) || (state == ST_HDR);
    // Frame error or a frame that ends inside the header
    assign hdr_abort = eth_in.user || eth_in.last;

    // Payload beats go straight on, the aligner registers them
    assign fwd_beat  = eth_in;
    assign fwd_valid = xfer && (state == ST_PAYLOAD);

    // ======================================================================
    // Header beat capture
    // ======================================================================
    always_ff @(posedge iClk) begin
        if (xfer && in_hdr) begin
            hdr_raw[beat_cnt] <= eth_in.data;
        end
    end

    // ======================================================================
    // Frame FSM
    // ======================================================================
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_IDLE;
            beat_cnt     <= '0;
            eth_ready    <= 1'b0;
            hdr_done     <= 1'b0;
            fwd_first    <= 1'b0;
            stat_dropped <= 1'b0;
        end else begin
            // Single-cycle strobes
            hdr_done     <= 1'b0;
            stat_dropped <= 1'b0;

            case (state)
                ST_IDLE, ST_HDR: begin
                    eth_ready <= 1'b1;
                    if (xfer) begin
                        if (hdr_abort) begin
                            // Early abort, rest of an errored frame is absorbed
                            stat_dropped <= 1'b1;
                            beat_cnt     <= '0;
                            state        <= eth_in.last ? ST_IDLE : ST_ABSORB;
                        end else if (beat_cnt == LAST_HDR) begin
                            // Header complete, hold input for the verdict
                            eth_ready <= 1'b0;
                            hdr_done  <= 1'b1;
                            beat_cnt  <= '0;
                            state     <= ST_VERDICT;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            state    <= ST_HDR;
                        end
                    end
                end

                ST_VERDICT: begin
                    // Accept has priority over drop
                    if (accept) begin
                        eth_ready <= fwd_ready;
                        fwd_first <= 1'b1;
                        state     <= ST_PAYLOAD;
                    end else if (drop) begin
                        eth_ready    <= 1'b1;
                        stat_dropped <= 1'b1;
                        state        <= ST_ABSORB;
                    end
                end

                ST_PAYLOAD: begin
                    // Ready follows the aligner one cycle late
                    eth_ready <= fwd_ready;
                    if (fwd_valid) begin
                        fwd_first <= 1'b0;
                        if (eth_in.last) begin
                            eth_ready <= 1'b1;
                            state     <= ST_IDLE;
                        end
                    end
                end

                ST_ABSORB: begin
                    // Swallow beats up to last, nothing leaves
                    eth_ready <= 1'b1;
                    if (xfer && eth_in.last) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // A beat reaches the aligner only after it granted room the cycle before
    a_fwd_granted: assert property (@(posedge iClk) disable iff (!arst_n)
        fwd_valid |-> $past(fwd_ready));

endmodule

// ==== verilog/hdr_extract.sv ====
`timescale 1ns/1ns

module hdr_extract
    import udp_rx_pkg::*;
(
    input  logic     iClk,
    input  logic     arst_n,
    input  hdr_raw_t hdr_raw,
    input  logic     hdr_done,
    output udp_hdr_t hdr,
    output logic     hdr_valid
);

    udp_hdr_t    hdr_next;
    logic [31:0] sum;

    // Frame byte n lives in beat n/4, lane n%4
    function automatic logic [7:0] raw_byte(input hdr_raw_t raw, input int unsigned n);
        raw_byte = raw[n / DATA_BYTES][8 * (n % DATA_BYTES) +: 8];
    endfunction

    // Multi-byte fields, first byte most significant
    function automatic logic [15:0] raw_word(input hdr_raw_t raw, input int unsigned n);
        raw_word = {raw_byte(raw, n), raw_byte(raw, n + 1)};
    endfunction

    function automatic logic [31:0] raw_dword(input hdr_raw_t raw, input int unsigned n);
        raw_dword = {raw_word(raw, n), raw_word(raw, n + 2)};
    endfunction

    function automatic logic [47:0] raw_mac(input hdr_raw_t raw, input int unsigned n);
        raw_mac = {raw_word(raw, n), raw_word(raw, n + 2), raw_word(raw, n + 4)};
    endfunction

    // ======================================================================
    // IPv4 header word sum, validator folds and checks it
    // ======================================================================
    always_comb begin
        sum = '0;
        for (int i = 0; i < IP_SUM_WORDS; i++) begin
            sum = sum + 32'(raw_word(hdr_raw, OFF_IP + 2 * i));
        end
    end

    // Field split
    always_comb begin
        hdr_next             = '0;
        hdr_next.dst_mac     = raw_mac(hdr_raw, OFF_DST_MAC);
        hdr_next.src_mac     = raw_mac(hdr_raw, OFF_SRC_MAC);
        hdr_next.ethertype   = raw_word(hdr_raw, OFF_ETHERTYPE);
        // Version in the high nibble, IHL in the low one
        {hdr_next.ip_version, hdr_next.ip_ihl} = raw_byte(hdr_raw, OFF_IP);
        hdr_next.protocol    = raw_byte(hdr_raw, OFF_PROTOCOL);
        hdr_next.total_len   = raw_word(hdr_raw, OFF_TOTAL_LEN);
        hdr_next.src_ip      = raw_dword(hdr_raw, OFF_SRC_IP);
        hdr_next.dst_ip      = raw_dword(hdr_raw, OFF_DST_IP);
        hdr_next.src_port    = raw_word(hdr_raw, OFF_SRC_PORT);
        hdr_next.dst_port    = raw_word(hdr_raw, OFF_DST_PORT);
        hdr_next.udp_len     = raw_word(hdr_raw, OFF_UDP_LEN);
        hdr_next.csum_accum  = sum;
        hdr_next.payload_len = hdr_next.udp_len - 16'(UDP_HDR_LEN);
    end

    // Header held until the next frame's capture completes
    always_ff @(posedge iClk) begin
        if (hdr_done) begin
            hdr <= hdr_next;
        end
    end

    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            hdr_valid <= 1'b0;
        end else begin
            hdr_valid <= hdr_done;
        end
    end

endmodule

// ==== payload_align/payload_align.sv ====
`timescale 1ns/1ns

module payload_align
    import udp_rx_pkg::*;
(
    input  logic       iClk,
    input  logic       arst_n,
    input  axis_beat_t fwd_beat,
    input  logic       fwd_valid,
    input  logic       fwd_first,
    output logic       fwd_ready,
    output axis_beat_t pay_out,
    output logic       pay_valid,
    input  logic       pay_ready,
    output logic       stat_received
);

    localparam int HOLD_W = PAY_OFFSET * 8;

    // Upper lanes of the previous beat, first in the stream
    logic [HOLD_W-1:0]     hold_data;
    // Pending tail beat after a last beat with more than two bytes
    logic                  flush_pend;
    logic [PAY_OFFSET-1:0] flush_keep;
    logic                  flush_user;
    // Second slot behind pay_out, catches the beat in flight while ready drops
    axis_beat_t            skid_beat;
    logic                  skid_valid;

    logic [2:0]            in_cnt;
    logic [2:0]            first_cnt;
    logic [DATA_BYTES-1:0] rem_keep;
    logic                  split_flush;
    logic                  zero_pay;
    logic                  prod_valid;
    axis_beat_t            prod_beat;

    function automatic logic [2:0] count_bytes(input logic [DATA_BYTES-1:0] keep);
        count_bytes = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            count_bytes = count_bytes + 3'(keep[i]);
        end
    endfunction

    // Low-aligned keep for n bytes
    function automatic logic [DATA_BYTES-1:0] keep_mask(input logic [2:0] n);
        keep_mask = DATA_BYTES'((5'd1 << n) - 5'd1);
    endfunction

    assign fwd_ready = !flush_pend && !skid_valid && (!pay_valid || pay_ready);

    // ======================================================================
    // Output beat generation
    // ======================================================================
    always_comb begin
        in_cnt      = count_bytes(fwd_beat.keep);
        first_cnt   = (in_cnt > 3'(PAY_OFFSET)) ? in_cnt - 3'(PAY_OFFSET) : 3'd0;
        rem_keep    = keep_mask(in_cnt - 3'(PAY_OFFSET));
        split_flush = 1'b0;
        zero_pay    = 1'b0;
        prod_valid  = 1'b0;
        prod_beat   = '0;
        if (flush_pend) begin
            // Tail with the held bytes only
            prod_valid     = !skid_valid;
            prod_beat.data = {{(DATA_W - HOLD_W){1'b0}}, hold_data};
            prod_beat.keep = {{(DATA_BYTES - PAY_OFFSET){1'b0}}, flush_keep};
            prod_beat.last = 1'b1;
            prod_beat.user = flush_user;
        end else if (fwd_valid && fwd_first) begin
            // Byte 40 beat, lanes 0-1 are the UDP checksum
            prod_valid     = fwd_beat.last && (first_cnt != 3'd0);
            zero_pay       = fwd_beat.last && (first_cnt == 3'd0);
            prod_beat.data = {{HOLD_W{1'b0}}, fwd_beat.data[DATA_W-1:HOLD_W]};
            prod_beat.keep = keep_mask(first_cnt);
            prod_beat.last = 1'b1;
            prod_beat.user = fwd_beat.user;
        end else if (fwd_valid) begin
            prod_valid     = 1'b1;
            prod_beat.data = {fwd_beat.data[DATA_W-HOLD_W-1:0], hold_data};
            prod_beat.keep = '1;
            if (fwd_beat.last) begin
                if (in_cnt > 3'(PAY_OFFSET)) begin
                    split_flush = 1'b1;
                end else begin
                    prod_beat.keep = keep_mask(in_cnt + 3'(PAY_OFFSET));
                    prod_beat.last = 1'b1;
                    prod_beat.user = fwd_beat.user;
                end
            end
        end
    end

    // Data path
    always_ff @(posedge iClk) begin
        if (fwd_valid) begin
            hold_data <= fwd_beat.data[DATA_W-1:HOLD_W];
        end
        if (split_flush) begin
            flush_keep <= rem_keep[PAY_OFFSET-1:0];
            flush_user <= fwd_beat.user;
        end
        if (!pay_valid || pay_ready) begin
            if (skid_valid) begin
                pay_out <= skid_beat;
            end else if (prod_valid) begin
                pay_out <= prod_beat;
            end
        end
        if (prod_valid) begin
            skid_beat <= prod_beat;
        end
    end

    // ======================================================================
    // Output register and skid slot control
    // ======================================================================
    always_ff @(posedge iClk or negedge arst_n) begin
        if (!arst_n) begin
            flush_pend    <= 1'b0;
            skid_valid    <= 1'b0;
            pay_valid     <= 1'b0;
            stat_received <= 1'b0;
        end else begin
            // Frame done when its final beat is queued, or it had no payload
            stat_received <= (prod_valid && prod_beat.last) || zero_pay;
            if (flush_pend && !skid_valid) begin
                flush_pend <= 1'b0;
            end else if (split_flush) begin
                flush_pend <= 1'b1;
            end
            if (!pay_valid || pay_ready) begin
                pay_valid  <= skid_valid || prod_valid;
                skid_valid <= skid_valid && prod_valid;
            end else if (prod_valid) begin
                skid_valid <= 1'b1;
            end
        end
    end

    a_pay_stable: assert property (@(posedge iClk) disable iff (!arst_n)
        pay_valid && !pay_ready |=> pay_valid && $stable(pay_out));

endmodule

// ==== verilog/udp_rx_top.sv ====
`timescale 1ns/1ns

module udp_rx_top
    import udp_rx_pkg::*;
(
    input  logic       iClk,
    input  logic       arst_n,
    // MAC side
    input  axis_beat_t eth_in,
    input  logic       eth_valid,
    output logic       eth_ready,
    // Realigned payload
    output axis_beat_t pay_out,
    output logic       pay_valid,
    input  logic       pay_ready,
    // Header to the validator and its answer
    output udp_hdr_t   hdr,
    output logic       hdr_valid,
    input  logic       accept,
    input  logic       drop,
    // Frame statistics
    output logic       stat_received,
    output logic       stat_dropped
);

    // Header beats towards the extractor
    hdr_raw_t   hdr_raw;
    logic       hdr_done;

    // Payload beats towards the aligner
    axis_beat_t fwd_beat;
    logic       fwd_valid;
    logic       fwd_first;
    logic       fwd_ready;

    // Input side, header capture and verdict handling
    rx_frame_ctrl u_frame_ctrl (
        .iClk, .arst_n,
        .eth_in, .eth_valid, .eth_ready,
        .hdr_raw, .hdr_done,
        .accept, .drop,
        .fwd_beat, .fwd_valid, .fwd_first, .fwd_ready,
        .stat_dropped
    );

    hdr_extract u_hdr_extract (
        .iClk, .arst_n, .hdr_raw, .hdr_done, .hdr, .hdr_valid
    );

    // Output side, two-byte shift down to lane 0
    payload_align u_payload_align (
        .iClk, .arst_n,
        .fwd_beat, .fwd_valid, .fwd_first, .fwd_ready,
        .pay_out, .pay_valid, .pay_ready,
        .stat_received
    );

endmodule

// ==== tests/tb_udp_rx_model.svh ====
// ======================================================================
// Frame model for the UDP receive path
// ======================================================================

// Appends a field, first byte most significant
function automatic void put_field(input logic [47:0] value, input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
        frame_bytes.push_back(value[8*i +: 8]);
    end
endfunction

// UDP over IPv4 frame with len payload bytes
// Expected header and payload are filled in alongside the frame bytes
function automatic void build_frame(input int len);
    frame_bytes.delete();
    exp_pay.delete();
    exp_hdr             = '0;
    exp_hdr.dst_mac     = {16'h0200, rand_bits(32)};
    exp_hdr.src_mac     = {16'h0210, rand_bits(32)};
    exp_hdr.ethertype   = 16'h0800;
    exp_hdr.ip_version  = 4'd4;
    exp_hdr.ip_ihl      = 4'd5;
    exp_hdr.protocol    = 8'd17;
    // IP total length covers the IP and UDP headers
    exp_hdr.total_len   = 16'(28 + len);
    exp_hdr.src_ip      = rand_bits(32);
    exp_hdr.dst_ip      = rand_bits(32);
    exp_hdr.src_port    = 16'(rand_bits(16));
    exp_hdr.dst_port    = 16'(rand_bits(16));
    exp_hdr.udp_len     = 16'(UDP_HDR_LEN + len);
    exp_hdr.payload_len = 16'(len);
    // Ethernet header
    put_field(exp_hdr.dst_mac, 6);
    put_field(exp_hdr.src_mac, 6);
    put_field(exp_hdr.ethertype, 2);
    // IPv4 header, DSCP 0, DF set, TTL 64, random ID and checksum
    put_field({exp_hdr.ip_version, exp_hdr.ip_ihl, 8'h00}, 2);
    put_field(exp_hdr.total_len, 2);
    put_field(rand_bits(16), 2);
    put_field(16'h4000, 2);
    put_field({8'd64, exp_hdr.protocol}, 2);
    put_field(rand_bits(16), 2);
    put_field(exp_hdr.src_ip, 4);
    put_field(exp_hdr.dst_ip, 4);
    // UDP header, checksum random
    put_field(exp_hdr.src_port, 2);
    put_field(exp_hdr.dst_port, 2);
    put_field(exp_hdr.udp_len, 2);
    put_field(rand_bits(16), 2);
    for (int i = 0; i < len; i++) begin
        exp_pay.push_back(8'(rand_bits(8)));
        frame_bytes.push_back(exp_pay[i]);
    end
    // Plain 32-bit sum of the 16-bit IP header words
    for (int i = 0; i < IP_SUM_WORDS; i++) begin
        exp_hdr.csum_accum = exp_hdr.csum_accum
            + 32'({frame_bytes[OFF_IP + 2*i], frame_bytes[OFF_IP + 2*i + 1]});
    end
endfunction

// ==== tests/tb_udp_rx.sv ====
`timescale 1ns/1ns

module tb_udp_rx
    import udp_rx_pkg::*;
();

    localparam logic [15:0] SEED    = 16'd13;
    localparam int          TIMEOUT = 200;
    // Frame kinds
    localparam int M_ACCEPT     = 0;
    localparam int M_DROP       = 1;
    localparam int M_ABORT_USER = 2;
    localparam int M_ABORT_LAST = 3;

    logic       iClk = 1'b0;
    logic       arst_n;
    axis_beat_t eth_in;
    logic       eth_valid;
    logic       eth_ready;
    axis_beat_t pay_out;
    logic       pay_valid;
    logic       pay_ready;
    udp_hdr_t   hdr;
    logic       hdr_valid;
    logic       accept;
    logic       drop;
    logic       stat_received;
    logic       stat_dropped;

    // Random sources, one for frame contents and one for pay_ready gaps
    logic [15:0] lfsr     = SEED;
    logic [15:0] gap_lfsr = SEED;
    bit          gaps_on;
    // Frame under test and what came out of the DUT
    logic [7:0]  frame_bytes[$];
    logic [7:0]  exp_pay[$];
    logic [7:0]  got_bytes[$];
    udp_hdr_t    exp_hdr;
    int          n_received;
    int          n_dropped;
    int          n_hdr;
    int          last_cnt;
    int          last_size;
    logic        last_user;
    logic        was_stalled = 1'b0;
    axis_beat_t  prev_out;
    int          errors       = 0;
    int          test_num     = 0;
    int          tests_failed = 0;

    udp_rx_top u_udp_rx_top (.*);

    always #10 iClk = ~iClk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        rand_bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr      = lfsr_next(lfsr);
            rand_bits = {rand_bits[30:0], lfsr[0]};
        end
    endfunction

    `include "tb_udp_rx_model.svh"

    task automatic compare(input string name, input logic [$bits(udp_hdr_t)-1:0] expected,
                           input logic [$bits(udp_hdr_t)-1:0] got);
        if (expected !== got) begin
            $display("FAILED %s expected %0h got %0h", name, expected, got);
            errors++;
        end
    endtask

    // ======================================================================
    // Output monitor and header check
    // ======================================================================
    always @(posedge iClk) begin
        if (arst_n) begin
            // A stalled beat must hold still
            if (was_stalled) begin
                compare("pay_valid", 1'b1, pay_valid);
                compare("pay_out", prev_out, pay_out);
            end
            if (pay_valid && pay_ready) begin
                for (int i = 0; i < DATA_BYTES; i++) begin
                    if (pay_out.keep[i]) begin
                        got_bytes.push_back(pay_out.data[8*i +: 8]);
                    end
                end
                if (pay_out.last) begin
                    last_cnt++;
                    last_size = got_bytes.size();
                    last_user = pay_out.user;
                end
            end
            if (hdr_valid) begin
                n_hdr++;
                compare("hdr.csum_accum", exp_hdr.csum_accum, hdr.csum_accum);
                compare("hdr.payload_len", exp_hdr.payload_len, hdr.payload_len);
                compare("hdr", exp_hdr, hdr);
            end
            n_received  += stat_received;
            n_dropped   += stat_dropped;
            was_stalled = pay_valid && !pay_ready;
            prev_out    = pay_out;
        end
    end

    // Back-pressure, random only while gaps are on
    always @(posedge iClk) begin
        #2;
        if (gaps_on) begin
            gap_lfsr  = lfsr_next(gap_lfsr);
            pay_ready = gap_lfsr[0];
        end else begin
            pay_ready = 1'b1;
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic send_frame(input int abort_at, input bit abort_last, input bit user_end);
        axis_beat_t beat;
        int         nbeats;
        int         waited;
        bit         ended;
        nbeats = (frame_bytes.size() + DATA_BYTES - 1) / DATA_BYTES;
        ended  = 1'b0;
        for (int k = 0; k < nbeats && !ended; k++) begin
            beat = '0;
            for (int i = 0; i < DATA_BYTES; i++) begin
                if (k * DATA_BYTES + i < frame_bytes.size()) begin
                    beat.data[8*i +: 8] = frame_bytes[k * DATA_BYTES + i];
                    beat.keep[i]        = 1'b1;
                end
            end
            beat.last = (k == nbeats - 1);
            beat.user = user_end && beat.last;
            // Early abort inside the header
            if (k == abort_at) begin
                beat.last = beat.last || abort_last;
                beat.user = beat.user || !abort_last;
            end
            eth_in    = beat;
            eth_valid = 1'b1;
            waited    = 0;
            do begin
                @(posedge iClk);
                waited++;
            end while (!eth_ready && waited < TIMEOUT);
            if (!eth_ready) begin
                $display("Timeout, input beat %0d was not taken in %0d cycles", k, TIMEOUT);
                errors++;
                ended = 1'b1;
            end
            #2;
            ended = ended || beat.last;
        end
        eth_valid = 1'b0;
    endtask

    // Validator answer, one cycle wide
    task automatic answer_verdict(input bit is_drop);
        int waited;
        waited = 0;
        do begin
            @(posedge iClk);
            waited++;
        end while (!hdr_valid && waited < TIMEOUT);
        if (!hdr_valid) begin
            $display("Timeout, no header valid within %0d cycles", TIMEOUT);
            errors++;
        end else begin
            #2;
            accept = !is_drop;
            drop   = is_drop;
            @(posedge iClk);
            #2;
            accept = 1'b0;
            drop   = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int len, input int mode, input bit user_end);
        int err_before;
        int exp_len;
        int abort_at;
        int waited;
        bit done;
        err_before = errors;
        exp_len    = (mode == M_ACCEPT) ? len : 0;
        abort_at   = (mode == M_ABORT_USER) ? 5 : (mode == M_ABORT_LAST) ? 7 : -1;
        build_frame(len);
        got_bytes.delete();
        n_received = 0;
        n_dropped  = 0;
        n_hdr      = 0;
        last_cnt   = 0;
        last_size  = 0;
        last_user  = 1'b0;
        fork
            send_frame(abort_at, mode == M_ABORT_LAST, user_end);
            if (mode <= M_DROP) begin
                answer_verdict(mode == M_DROP);
            end
        join
        waited = 0;
        do begin
            @(posedge iClk);
            waited++;
            done = (mode == M_ACCEPT) ? (n_received > 0 && got_bytes.size() >= exp_len)
                                      : (n_dropped > 0);
        end while (!done && waited < TIMEOUT);
        if (!done) begin
            $display("Timeout, frame of test %0d did not finish", test_num + 1);
            errors++;
        end
        // Quiet window to catch stray beats or pulses
        repeat (4) @(posedge iClk);
        #2;
        compare("stat_received", mode == M_ACCEPT, n_received);
        compare("stat_dropped", mode != M_ACCEPT, n_dropped);
        compare("hdr_valid", mode <= M_DROP, n_hdr);
        compare("pay_out byte count", exp_len, got_bytes.size());
        for (int i = 0; i < exp_len && i < got_bytes.size(); i++) begin
            compare("pay_out.data", exp_pay[i], got_bytes[i]);
        end
        compare("pay_out.last count", exp_len > 0, last_cnt);
        if (exp_len > 0) begin
            compare("pay_out.last position", exp_len, last_size);
            compare("pay_out.user", user_end, last_user);
        end
        test_num++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("Test %0d %-30s %0d errors", test_num, name, errors - err_before);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        arst_n    = 1'b0;
        eth_in    = '0;
        eth_valid = 1'b0;
        pay_ready = 1'b1;
        accept    = 1'b0;
        drop      = 1'b0;
        gaps_on   = 1'b0;
        repeat (10) @(posedge iClk);
        #2;
        arst_n = 1'b1;
        for (int len = 0; len < 14; len++) begin
            run_test($sformatf("accept, %0d payload bytes", len), len, M_ACCEPT, 1'b0);
        end
        run_test("drop verdict", 9, M_DROP, 1'b0);
        run_test("accept after drop", 7, M_ACCEPT, 1'b0);
        run_test("user inside header", 6, M_ABORT_USER, 1'b0);
        run_test("last inside header", 6, M_ABORT_LAST, 1'b0);
        run_test("accept after abort", 4, M_ACCEPT, 1'b0);
        gaps_on = 1'b1;
        for (int k = 0; k < 8; k++) begin
            run_test($sformatf("pay_ready gaps, frame %0d", k), rand_bits(4) % 14, M_ACCEPT, 1'b0);
        end
        gaps_on = 1'b0;
        run_test("user on last beat with flush", 5, M_ACCEPT, 1'b1);
        run_test("user on last beat", 3, M_ACCEPT, 1'b1);
        $display("%0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+tests
common/udp_rx_pkg.sv
frame_ctrl/rx_frame_ctrl.sv
verilog/hdr_extract.sv
payload_align/payload_align.sv
verilog/udp_rx_top.sv
tests/tb_udp_rx.sv
